/* files.f */
+incdir+design
design/pinctl_pkg.sv
design/gpio_regs.sv
design/jtag_mux.sv
design/padring.sv
design/pin_top.sv
sim/pin_sva.sv
sim/pin_tb.sv

/* Makefile */
# Verilator build and run for the pin control testbench

VERILATOR ?= verilator
TOP       ?= pin_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* sim/pin_tb.sv */
/* Pin control testbench: clock and reset, table of AXI4-Lite accesses
   with pad stimulus, reference model of the pad path, pass or fail */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module pin_tb;
  import pinctl_pkg::*;

  localparam logic [1:0]           Okay       = 2'b00;
  localparam logic [1:0]           SlvErr     = 2'b10;
  localparam logic [7:0]           AttrEnd    = 8'(`REG_ATTR0 + 4 * `NUM_PADS);
  localparam logic [`NUM_PADS-1:0] TieOff     = `TIE_OFF;
  localparam int                   NumEntries = 27;
  localparam int                   CycleLimit = NumEntries * 40 + 100;

  typedef enum logic {OP_WR, OP_RD} op_e;

  typedef struct packed {
    op_e                  op;
    logic [7:0]           addr;
    logic [31:0]          data;
    logic [3:0]           strb;
    logic [`NUM_PADS-1:0] pad;    // pad_i during the access
    logic                 tdo;
    logic [1:0]           resp;   // Expected response code
  } entry_t;

  logic                 clk = 1'b0;
  logic                 rst;
  axi_req_t             req;
  axi_rsp_t             rsp;
  logic [`NUM_PADS-1:0] pad_in, pad_out, pad_oe;
  logic                 tck, tms, tdi, tdo;
  integer               seed = 32'h8d5b;
  int                   cycles = 0;
  entry_t               tbl [NumEntries];

  // Reference register state
  logic [`NUM_PADS-1:0] m_out, m_oe;
  pad_attr_u            m_attr [`NUM_PADS];

  pin_top dut0 (
    .clk_i      ( clk     ),
    .rst_i      ( rst     ),
    .axi_req_i  ( req     ),
    .axi_rsp_o  ( rsp     ),
    .pad_i      ( pad_in  ),
    .pad_o      ( pad_out ),
    .pad_oe_o   ( pad_oe  ),
    .jtag_tck_o ( tck     ),
    .jtag_tms_o ( tms     ),
    .jtag_tdi_o ( tdi     ),
    .jtag_tdo_i ( tdo     )
  );

  bind pin_top pin_sva u_sva (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .axi_req_i     ( axi_req_i   ),
    .axi_rsp_i     ( axi_rsp_o   ),
    .pad_oe_i      ( pad_oe_o    ),
    .jtag_active_i ( jtag_active )
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CycleLimit) begin
      $display("Timeout: the run went past %0d clock cycles", CycleLimit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [`NUM_PADS-1:0] ring_view(input logic [`NUM_PADS-1:0] pad);
    logic [`NUM_PADS-1:0] r;
    for (int i = 0; i < `NUM_PADS; i++) begin
      r[i] = m_attr[i].field.in_dis ? 1'b0 : pad[i] ^ m_attr[i].field.invert;
    end
    return r;
  endfunction

  // Register block view with tie-offs while the strap is high
  function automatic logic [`NUM_PADS-1:0] core_view(input logic [`NUM_PADS-1:0] pad);
    logic [`NUM_PADS-1:0] r;
    r = ring_view(pad);
    if (r[`JTAG_EN_IDX]) begin
      r[`TDO_IDX:`TCK_IDX] = TieOff[`TDO_IDX:`TCK_IDX];
    end
    return r;
  endfunction

  // Expected {pad_oe_o, pad_o}
  function automatic logic [2*`NUM_PADS-1:0] pin_model(input logic [`NUM_PADS-1:0] pad,
                                                      input logic                 tdo_v);
    logic [`NUM_PADS-1:0] r, o, oe;
    logic                 drv;
    r  = ring_view(pad);
    o  = m_out;
    oe = m_oe;
    if (r[`JTAG_EN_IDX]) begin
      o[`TDO_IDX:`TCK_IDX]  = '0;
      oe[`TDO_IDX:`TCK_IDX] = '0;
      o[`TDO_IDX]           = tdo_v;
      oe[`TDO_IDX]          = 1'b1;
    end
    for (int i = 0; i < `NUM_PADS; i++) begin
      drv = o[i] ^ m_attr[i].field.invert;
      o[i] = m_attr[i].field.od ? 1'b0 : drv;
      if (m_attr[i].field.od) begin
        oe[i] = oe[i] & ~drv;  // Low only
      end
    end
    return {oe, o};
  endfunction

  function automatic logic [`NUM_PADS-1:0] lane_merge(input logic [`NUM_PADS-1:0] old,
                                                      input logic [31:0] d,
                                                      input logic [3:0]  s);
    logic [`NUM_PADS-1:0] v;
    v = old;
    if (s[0]) begin
      v[7:0] = d[7:0];
    end
    if (s[1]) begin
      v[`NUM_PADS-1:8] = d[`NUM_PADS-1:8];
    end
    return v;
  endfunction

  function automatic logic is_attr(input logic [7:0] addr);
    return (addr >= `REG_ATTR0) && (addr < AttrEnd) && (addr[1:0] == 2'b00);
  endfunction

  // Only accepted writes change state
  function automatic void model_write(input entry_t e);
    logic [7:0] off;
    off = e.addr - `REG_ATTR0;
    if (e.addr == `REG_OUT) begin
      m_out = lane_merge(m_out, e.data, e.strb);
    end else if (e.addr == `REG_OE) begin
      m_oe = lane_merge(m_oe, e.data, e.strb);
    end else if (is_attr(e.addr) && e.strb[0]) begin
      m_attr[off[5:2]].raw = e.data[7:0];
    end
  endfunction

  function automatic logic [31:0] model_read(input entry_t e);
    logic [7:0]           off;
    logic [31:0]          data;
    logic [`NUM_PADS-1:0] rv;
    off  = e.addr - `REG_ATTR0;
    data = '0;
    rv   = ring_view(e.pad);
    if (e.addr == `REG_OUT) begin
      data[`NUM_PADS-1:0] = m_out;
    end else if (e.addr == `REG_OE) begin
      data[`NUM_PADS-1:0] = m_oe;
    end else if (e.addr == `REG_IN) begin
      data[`NUM_PADS-1:0] = core_view(e.pad);
    end else if (e.addr == `REG_STATUS) begin
      data[0] = rv[`JTAG_EN_IDX];
    end else if (is_attr(e.addr)) begin
      data[7:0] = m_attr[off[5:2]].raw;
    end
    return data;
  endfunction

  //////////////////////////////////////////////////
  // AXI4-Lite access with random response stall
  //////////////////////////////////////////////////

  task automatic axi_access(input entry_t e, output logic [1:0] resp, output logic [31:0] rdata);
    logic wr;
    logic accepted;
    int   stall;
    wr          = (e.op == OP_WR);
    accepted    = 1'b0;
    stall       = $unsigned($random(seed)) % 4;
    req.awaddr  = e.addr;
    req.araddr  = e.addr;
    req.wdata   = e.data;
    req.wstrb   = e.strb;
    req.awvalid = wr;
    req.wvalid  = wr;
    req.arvalid = !wr;
    while (!accepted) begin
      #1;  // Ready settles halfway to the rising edge
      accepted = wr ? rsp.awready : rsp.arready;
      if (wr) begin
        check_val("wready next to awready", 32'(rsp.wready), 32'(rsp.awready));
      end
      @(negedge clk);
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.arvalid = 1'b0;
    resp  = wr ? rsp.bresp : rsp.rresp;
    rdata = rsp.rdata;
    for (int n = 0; n <= stall; n++) begin
      if (n > 0) begin
        @(negedge clk);
      end
      check_val("response valid", 32'(wr ? rsp.bvalid : rsp.rvalid), 32'h1);
      check_val("held response code", 32'(wr ? rsp.bresp : rsp.rresp), 32'(resp));
      if (!wr) begin
        check_val("held read data", rsp.rdata, rdata);
      end
    end
    req.bready = wr;
    req.rready = !wr;
    @(negedge clk);
    req.bready = 1'b0;
    req.rready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    entry_t                 e;
    logic [1:0]             resp;
    logic [31:0]            rdata;
    logic [2*`NUM_PADS-1:0] exp_pins;
    logic [`NUM_PADS-1:0]   rv;
    rst    = 1'b1;
    req    = '0;
    pad_in = '0;
    tdo    = 1'b0;
    m_out  = '0;
    m_oe   = '0;
    foreach (m_attr[i]) begin
      m_attr[i] = '0;
    end
    tbl = '{
      //  op     addr         data           strb  pad      tdo   resp
      '{OP_WR, `REG_OUT,    32'h0000_00A5, 4'hF, 12'h000, 1'b0, Okay},
      '{OP_WR, `REG_OE,     32'h0000_00FF, 4'hF, 12'h000, 1'b0, Okay},
      '{OP_RD, `REG_OUT,    32'h0,         4'h0, 12'h000, 1'b0, Okay},
      '{OP_RD, `REG_OE,     32'h0,         4'h0, 12'h000, 1'b0, Okay},
      '{OP_WR, `REG_OUT,    32'h0000_0C3C, 4'h2, 12'h000, 1'b0, Okay},   // Upper lane only
      '{OP_WR, `REG_OE,     32'h0000_0F00, 4'h2, 12'h000, 1'b0, Okay},
      '{OP_WR, 8'h10,       32'h0000_0001, 4'hF, 12'h000, 1'b0, Okay},   // Pad 0 invert
      '{OP_WR, 8'h14,       32'h0000_0004, 4'hF, 12'h000, 1'b0, Okay},   // Pad 1 open drain
      '{OP_WR, 8'h18,       32'h0000_0005, 4'hF, 12'h000, 1'b0, Okay},
      '{OP_WR, 8'h1C,       32'h0000_0002, 4'hF, 12'h000, 1'b0, Okay},   // Pad 3 input off
      '{OP_RD, 8'h18,       32'h0,         4'h0, 12'h000, 1'b0, Okay},
      '{OP_RD, `REG_IN,     32'h0,         4'h0, 12'h05F, 1'b0, Okay},
      '{OP_RD, `REG_IN,     32'h0,         4'h0, 12'h360, 1'b0, Okay},
      '{OP_RD, `REG_STATUS, 32'h0,         4'h0, 12'h780, 1'b1, Okay},   // Strap high
      '{OP_RD, `REG_IN,     32'h0,         4'h0, 12'h780, 1'b1, Okay},
      '{OP_WR, `REG_OUT,    32'h0000_0FFF, 4'hF, 12'h280, 1'b0, Okay},
      '{OP_RD, `REG_OUT,    32'h0,         4'h0, 12'h280, 1'b0, Okay},
      '{OP_RD, `REG_STATUS, 32'h0,         4'h0, 12'h500, 1'b0, Okay},
      '{OP_WR, `REG_IN,     32'h0000_0123, 4'hF, 12'h500, 1'b0, SlvErr},
      '{OP_WR, `REG_STATUS, 32'h0000_0001, 4'hF, 12'h500, 1'b0, SlvErr},
      '{OP_WR, 8'h40,       32'h0000_00FF, 4'hF, 12'h500, 1'b0, SlvErr},  // Past last attr
      '{OP_WR, 8'h84,       32'h0000_00FF, 4'hF, 12'h500, 1'b0, SlvErr},
      '{OP_RD, 8'h44,       32'h0,         4'h0, 12'h500, 1'b0, SlvErr},
      '{OP_RD, `REG_OUT,    32'h0,         4'h0, 12'h500, 1'b0, Okay},
      '{OP_RD, 8'h10,       32'h0,         4'h0, 12'h500, 1'b0, Okay},
      '{OP_WR, 8'h3C,       32'h0000_0104, 4'h1, 12'h500, 1'b0, Okay},   // Byte 0 only
      '{OP_RD, 8'h3C,       32'h0,         4'h0, 12'h500, 1'b0, Okay}
    };
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_val("pad_oe_o after reset", 32'(pad_oe), 32'h0);
    foreach (tbl[k]) begin
      e      = tbl[k];
      pad_in = e.pad;
      tdo    = e.tdo;
      repeat (3) @(negedge clk);  // Input synchroniser settles
      axi_access(e, resp, rdata);
      check_val("response code", 32'(resp), 32'(e.resp));
      if (e.op == OP_WR) begin
        if (e.resp == Okay) begin
          model_write(e);
        end
      end else begin
        check_val("read data", rdata, model_read(e));
      end
      exp_pins = pin_model(e.pad, e.tdo);
      rv       = ring_view(e.pad);
      check_val("pad_o", 32'(pad_out), 32'(exp_pins[`NUM_PADS-1:0]));
      check_val("pad_oe_o", 32'(pad_oe), 32'(exp_pins[2*`NUM_PADS-1:`NUM_PADS]));
      check_val("tck, tms, tdi", 32'({tck, tms, tdi}),
                32'({rv[`TCK_IDX], rv[`TMS_IDX], rv[`TDI_IDX]} & {3{rv[`JTAG_EN_IDX]}}));
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/pin_sva.sv */
/* Bound assertions on the AXI4-Lite response handshake
   and the JTAG overlay */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module pin_sva (
  input logic                 clk_i,
  input logic                 rst_i,
  input pinctl_pkg::axi_req_t axi_req_i,
  input pinctl_pkg::axi_rsp_t axi_rsp_i,
  input logic [`NUM_PADS-1:0] pad_oe_i,
  input logic                 jtag_active_i
);

  // Write response held until taken
  bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    axi_rsp_i.bvalid && !axi_req_i.bready |=> axi_rsp_i.bvalid && $stable(axi_rsp_i.bresp))
    else $error("bvalid or bresp changed before bready");

  rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    axi_rsp_i.rvalid && !axi_req_i.rready |=> axi_rsp_i.rvalid && $stable(axi_rsp_i.rdata))
    else $error("rvalid or rdata changed before rready");

  // TCK is an input to the chip while the overlay owns it
  tck_not_driven: assert property (@(posedge clk_i) disable iff (rst_i)
    jtag_active_i |-> !pad_oe_i[`TCK_IDX])
    else $error("TCK pad driven while JTAG is active");

  reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !axi_rsp_i.bvalid && !axi_rsp_i.rvalid)
    else $error("response valid right after reset");

endmodule

`default_nettype wire

/* design/pin_top.sv */
/* Board-level pin control top: register block, JTAG overlay mux
   and pad ring */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module pin_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // AXI4-Lite register port
  input  pinctl_pkg::axi_req_t  axi_req_i,
  output pinctl_pkg::axi_rsp_t  axi_rsp_o,
  // Pad pins
  input  logic [`NUM_PADS-1:0]  pad_i,
  output logic [`NUM_PADS-1:0]  pad_o,
  output logic [`NUM_PADS-1:0]  pad_oe_o,
  // JTAG port
  output logic                  jtag_tck_o,
  output logic                  jtag_tms_o,
  output logic                  jtag_tdi_o,
  input  logic                  jtag_tdo_i
);
  import pinctl_pkg::*;

  pad_bus_t                  core_bus;   // Register block side
  pad_bus_t                  ring_bus;   // Pad ring side
  pad_attr_u [`NUM_PADS-1:0] pad_attr;
  logic                      jtag_active;

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////

  gpio_regs u_regs (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .axi_req_i     ( axi_req_i     ),
    .axi_rsp_o     ( axi_rsp_o     ),
    .core_out_o    ( core_bus.out  ),
    .core_oe_o     ( core_bus.oe   ),
    .core_in_i     ( core_bus.in   ),
    .jtag_active_i ( jtag_active   ),
    .attr_o        ( pad_attr      )
  );

  //////////////////////////////////////////////////
  // JTAG overlay
  //////////////////////////////////////////////////

  jtag_mux u_jtag_mux (
    .core_out_i    ( core_bus.out  ),
    .core_oe_i     ( core_bus.oe   ),
    .core_in_o     ( core_bus.in   ),
    .ring_out_o    ( ring_bus.out  ),
    .ring_oe_o     ( ring_bus.oe   ),
    .ring_in_i     ( ring_bus.in   ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_active_o ( jtag_active   )
  );

  //////////////////////////////////////////////////
  // Pad ring
  //////////////////////////////////////////////////

  padring u_padring (
    .pad_i         ( pad_i         ),
    .pad_o         ( pad_o         ),
    .pad_oe_o      ( pad_oe_o      ),
    .ring_out_i    ( ring_bus.out  ),
    .ring_oe_i     ( ring_bus.oe   ),
    .ring_in_o     ( ring_bus.in   ),
    .attr_i        ( pad_attr      )
  );

endmodule

`default_nettype wire

/* design/padring.sv */
/* Pad ring model: per-pad inversion, input disable and open drain
   between the pad pins and the inner pad bundle */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module padring (
  // Pins
  input  logic [`NUM_PADS-1:0]                  pad_i,
  output logic [`NUM_PADS-1:0]                  pad_o,
  output logic [`NUM_PADS-1:0]                  pad_oe_o,
  // Inner side
  input  logic [`NUM_PADS-1:0]                  ring_out_i,
  input  logic [`NUM_PADS-1:0]                  ring_oe_i,
  output logic [`NUM_PADS-1:0]                  ring_in_o,
  // Per-pad attributes
  input  pinctl_pkg::pad_attr_u [`NUM_PADS-1:0] attr_i
);

  localparam int unsigned NumPads = `NUM_PADS;

  //////////////////////////////////////////////////
  // Pad cells
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumPads; i++) begin : g_pad
    logic inv;
    logic drv;    // Output level after inversion

    assign inv = attr_i[i].field.invert;
    assign drv = ring_out_i[i] ^ inv;

    // Input path, disable wins over inversion
    assign ring_in_o[i] = attr_i[i].field.in_dis ? 1'b0 : (pad_i[i] ^ inv);

    // Open drain pulls low by enabling the driver only for a 0
    assign pad_o[i]    = attr_i[i].field.od ? 1'b0 : drv;
    assign pad_oe_o[i] = attr_i[i].field.od ? (ring_oe_i[i] & ~drv)
                                            : ring_oe_i[i];
  end

endmodule

`default_nettype wire

/* design/jtag_mux.sv */
/* JTAG overlay multiplexer: strap pad hands DIO0 to DIO3 to the JTAG port
   and ties off the core view of those pads */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module jtag_mux (
  // Core side
  input  logic [`NUM_PADS-1:0] core_out_i,
  input  logic [`NUM_PADS-1:0] core_oe_i,
  output logic [`NUM_PADS-1:0] core_in_o,
  // Pad ring side
  output logic [`NUM_PADS-1:0] ring_out_o,
  output logic [`NUM_PADS-1:0] ring_oe_o,
  input  logic [`NUM_PADS-1:0] ring_in_i,
  // JTAG port
  output logic                 jtag_tck_o,
  output logic                 jtag_tms_o,
  output logic                 jtag_tdi_o,
  input  logic                 jtag_tdo_i,
  output logic                 jtag_active_o
);

  localparam int unsigned          NumPads = `NUM_PADS;
  localparam logic [NumPads-1:0]   OvlMask = (NumPads'(1) << `TCK_IDX) |
                                             (NumPads'(1) << `TMS_IDX) |
                                             (NumPads'(1) << `TDI_IDX) |
                                             (NumPads'(1) << `TDO_IDX);
  localparam logic [NumPads-1:0]   TieOff  = `TIE_OFF;

  assign jtag_active_o = ring_in_i[`JTAG_EN_IDX];  // Strap high selects JTAG

  // Core sees fixed values on the overlaid pads
  assign core_in_o = jtag_active_o ? ((ring_in_i & ~OvlMask) | (TieOff & OvlMask))
                                   : ring_in_i;

  always_comb begin
    ring_out_o = core_out_i;
    ring_oe_o  = core_oe_i;
    if (jtag_active_o) begin
      ring_out_o = core_out_i & ~OvlMask;  // Core blocked on all four
      ring_oe_o  = core_oe_i & ~OvlMask;   // TCK, TMS, TDI become inputs
      ring_out_o[`TDO_IDX] = jtag_tdo_i;
      ring_oe_o[`TDO_IDX]  = 1'b1;
    end
  end

  // JTAG inputs idle low outside the overlay
  assign jtag_tck_o = jtag_active_o & ring_in_i[`TCK_IDX];
  assign jtag_tms_o = jtag_active_o & ring_in_i[`TMS_IDX];
  assign jtag_tdi_o = jtag_active_o & ring_in_i[`TDI_IDX];

endmodule

`default_nettype wire

/* design/gpio_regs.sv */
/* AXI4-Lite register block: output, enable and attribute registers,
   two-flop input synchroniser, JTAG status */
`timescale 1ns/10ps
`default_nettype none
`include "pinctl_macros.svh"

module gpio_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  pinctl_pkg::axi_req_t                  axi_req_i,
  output pinctl_pkg::axi_rsp_t                  axi_rsp_o,
  output logic [`NUM_PADS-1:0]                  core_out_o,
  output logic [`NUM_PADS-1:0]                  core_oe_o,
  input  logic [`NUM_PADS-1:0]                  core_in_i,
  input  logic                                  jtag_active_i,
  output pinctl_pkg::pad_attr_u [`NUM_PADS-1:0] attr_o
);
  import pinctl_pkg::*;

  localparam logic [1:0]       RespOkay   = 2'b00;
  localparam logic [1:0]       RespSlvErr = 2'b10;
  localparam int unsigned      WordW      = `ADDR_W - 2;
  localparam int unsigned      IdxW       = $clog2(`NUM_PADS);
  localparam logic [WordW-1:0] AttrBase   = WordW'(`REG_ATTR0 >> 2);
  localparam logic [WordW-1:0] AttrEnd    = AttrBase + WordW'(`NUM_PADS);

  // Attribute window lookup, hit flag on top of the pad index
  function automatic logic [IdxW:0] attr_lookup(input logic [`ADDR_W-1:0] addr);
    logic [WordW-1:0] word;
    logic [WordW-1:0] off;
    word = addr[`ADDR_W-1:2];
    off  = word - AttrBase;
    return {(word >= AttrBase) && (word < AttrEnd), off[IdxW-1:0]};
  endfunction

  // Byte lane merge of a write into a pad-wide register
  function automatic logic [`NUM_PADS-1:0] merge_bytes(input logic [`NUM_PADS-1:0] old,
                                                       input logic [31:0]          data,
                                                       input logic [3:0]           strb);
    logic [31:0] res;
    res = 32'(old);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res[`NUM_PADS-1:0];
  endfunction

  logic                      wr_hs, rd_hs;
  logic [IdxW:0]             wr_attr, rd_attr;
  logic                      wr_out, wr_oe, wr_err;
  logic [31:0]               rd_data;
  logic                      rd_err;
  logic [`NUM_PADS-1:0]      out_q, oe_q;
  pad_attr_u [`NUM_PADS-1:0] attr_q;
  logic [`NUM_PADS-1:0]      in_meta_q, in_sync_q;
  logic                      bvalid_q, rvalid_q;
  logic [1:0]                bresp_q, rresp_q;
  logic [31:0]               rdata_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign wr_hs   = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_hs   = axi_req_i.arvalid & ~rvalid_q;
  assign wr_attr = attr_lookup(axi_req_i.awaddr);
  assign rd_attr = attr_lookup(axi_req_i.araddr);
  assign wr_out  = (axi_req_i.awaddr == `REG_OUT);
  assign wr_oe   = (axi_req_i.awaddr == `REG_OE);
  assign wr_err  = ~(wr_out | wr_oe | wr_attr[IdxW]);  // IN and STATUS are read-only

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (axi_req_i.araddr == `REG_OUT) begin
      rd_data[`NUM_PADS-1:0] = out_q;
    end else if (axi_req_i.araddr == `REG_OE) begin
      rd_data[`NUM_PADS-1:0] = oe_q;
    end else if (axi_req_i.araddr == `REG_IN) begin
      rd_data[`NUM_PADS-1:0] = in_sync_q;
    end else if (axi_req_i.araddr == `REG_STATUS) begin
      rd_data[0] = jtag_active_i;
    end else if (rd_attr[IdxW]) begin
      rd_data[7:0] = attr_q[rd_attr[IdxW-1:0]].raw;
    end else begin
      rd_err = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q  <= '0;
      oe_q   <= '0;
      attr_q <= '0;
    end else if (wr_hs && !wr_err) begin
      if (wr_out) begin
        out_q <= merge_bytes(out_q, axi_req_i.wdata, axi_req_i.wstrb);
      end
      if (wr_oe) begin
        oe_q <= merge_bytes(oe_q, axi_req_i.wdata, axi_req_i.wstrb);
      end
      if (wr_attr[IdxW] && axi_req_i.wstrb[0]) begin
        attr_q[wr_attr[IdxW-1:0]].raw <= axi_req_i.wdata[7:0];  // Byte 0 only
      end
    end
  end

  // Pad input synchroniser
  always_ff @(posedge clk_i) begin
    in_meta_q <= core_in_i;
    in_sync_q <= in_meta_q;
  end

  // Response valids
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axi_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axi_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload, held while valid
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q <= wr_err ? RespSlvErr : RespOkay;
    end
    if (rd_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? RespSlvErr : RespOkay;
    end
  end

  always_comb begin
    axi_rsp_o.awready = wr_hs;
    axi_rsp_o.wready  = wr_hs;
    axi_rsp_o.bvalid  = bvalid_q;
    axi_rsp_o.bresp   = bresp_q;
    axi_rsp_o.arready = rd_hs;
    axi_rsp_o.rvalid  = rvalid_q;
    axi_rsp_o.rdata   = rdata_q;
    axi_rsp_o.rresp   = rresp_q;
  end

  assign core_out_o = out_q;
  assign core_oe_o  = oe_q;
  assign attr_o     = attr_q;

endmodule

`default_nettype wire

/* design/pinctl_pkg.sv */
/* Pad attribute union, pad bundle struct,
   AXI4-Lite request and response structs */
`default_nettype none
`include "pinctl_macros.svh"

package pinctl_pkg;

  //////////////////////////////////////////////////
  // Pad side types
  //////////////////////////////////////////////////

  // One attribute byte per pad
  typedef union packed {
    logic [7:0] raw;          // As stored and read back
    struct packed {
      logic [4:0] rsvd;
      logic       od;         // Open drain, drives lows only
      logic       in_dis;     // Input reads 0
      logic       invert;     // Polarity swap on in and out
    } field;
  } pad_attr_u;

  typedef struct packed {
    logic [`NUM_PADS-1:0] out;
    logic [`NUM_PADS-1:0] oe;
    logic [`NUM_PADS-1:0] in;   // Flows back toward the core
  } pad_bus_t;

  //////////////////////////////////////////////////
  // AXI4-Lite
  //////////////////////////////////////////////////

  typedef struct packed {
    logic              awvalid;
    logic [`ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              bready;
    logic              arvalid;
    logic [`ADDR_W-1:0] araddr;
    logic              rready;
  } axi_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_rsp_t;

endpackage

`default_nettype wire

/* design/pinctl_macros.svh */
/* Pad counts, strap and JTAG pad indices, register map and tie-off value
   for the pin control subsystem */
`ifndef PINCTL_MACROS_SVH
`define PINCTL_MACROS_SVH

// Pad counts
`define NUM_MIO      8
`define NUM_DIO      4
`define NUM_PADS     (`NUM_MIO + `NUM_DIO)

// Strap pad and JTAG pins, flat indices (DIO0 to DIO3)
`define JTAG_EN_IDX  7
`define TCK_IDX      8
`define TMS_IDX      9
`define TDI_IDX      10
`define TDO_IDX      11

// Core view of overlaid pads, TMS shares a chip select pad that idles high
`define TIE_OFF      12'h200

// Register map
`define ADDR_W       8
`define REG_OUT      8'h00
`define REG_OE       8'h04
`define REG_IN       8'h08
`define REG_STATUS   8'h0C
`define REG_ATTR0    8'h10

`endif
